/* hdl/ntt_add_sub_mod.sv */
//==========================================================
// Modular adder / subtractor mod q
// Operands below q, one correction, one cycle of latency
//==========================================================
module ntt_add_sub_mod
    import ntt_defines_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                sub_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,
    output logic [REG_SIZE-1:0] res_o
);

    // One extra bit for carry or borrow
    logic [REG_SIZE:0]   sum;
    logic [REG_SIZE:0]   diff;
    logic [REG_SIZE-1:0] res_d;
    logic [REG_SIZE-1:0] res_q;

    always_comb begin
        sum  = {1'b0, opa_i} + {1'b0, opb_i};
        diff = {1'b0, opa_i} - {1'b0, opb_i};
        if (sub_i) begin
            // Borrow lands in the top bit, wrap back up by q
            res_d = diff[REG_SIZE] ? REG_SIZE'(diff + {1'b0, NTT_Q}) : diff[REG_SIZE-1:0];
        end else begin
            // Sum is below 2q, so one subtraction is enough
            res_d = (sum >= {1'b0, NTT_Q}) ? REG_SIZE'(sum - {1'b0, NTT_Q})
                                           : sum[REG_SIZE-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_q <= '0;
        end else if (zeroize_i) begin
            res_q <= '0;
        end else begin
            res_q <= res_d;
        end
    end

    assign res_o = res_q;

    // Holds only while every upstream producer keeps its operands below q
    a_res_reduced: assert property (@(posedge clk) disable iff (!reset_n) res_o < NTT_Q);

endmodule

/* hdl/ntt_bf_top.sv */
//==========================================================
// NTT butterfly top level
// Results BF_LAT edges after capture, never stalls
//==========================================================
module ntt_bf_top
    import ntt_defines_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,

    // Operation in, taken on every edge with valid_i high
    input  logic                valid_i,
    input  mode_t               mode_i,
    input  logic                accumulate_i,
    input  logic [REG_SIZE-1:0] opu_i,
    input  logic [REG_SIZE-1:0] opv_i,
    input  logic [REG_SIZE-1:0] opw_i,

    // Results, consumed on the cycle valid_o is high
    output logic                valid_o,
    output logic [REG_SIZE-1:0] u_o,
    output logic [REG_SIZE-1:0] v_o,
    output logic [REG_SIZE-1:0] pwm_res_o
);

    // Producer side driven straight from the ports
    ntt_op_if op_if ();

    assign op_if.valid      = valid_i;
    assign op_if.mode       = mode_i;
    assign op_if.accumulate = accumulate_i;
    assign op_if.opu        = opu_i;
    assign op_if.opv        = opv_i;
    assign op_if.opw        = opw_i;

    ntt_butterfly i_ntt_butterfly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .op_i      (op_if),
        .valid_o   (valid_o),
        .u_o       (u_o),
        .v_o       (v_o),
        .pwm_res_o (pwm_res_o)
    );

endmodule

/* hdl/ntt_butterfly.sv */
//==========================================================
// Five-mode NTT butterfly mod q
// CT, GS, PWM, PWA, PWS with the same 5-cycle latency
//==========================================================
module ntt_butterfly
    import ntt_defines_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    ntt_op_if.consumer          op_i,
    output logic                valid_o,
    output logic [REG_SIZE-1:0] u_o,
    output logic [REG_SIZE-1:0] v_o,
    output logic [REG_SIZE-1:0] pwm_res_o
);

    // Control that travels alongside each operation
    typedef struct packed {
        logic  valid;
        mode_t mode;
        logic  accumulate;
    } bf_tag_t;

    // Tag at input, at multiplier output, at result
    bf_tag_t tag_s0;
    bf_tag_t tag_s4;
    bf_tag_t tag_s5;

    // Input operands, zero when idle
    logic [REG_SIZE-1:0] opu_s0;
    logic [REG_SIZE-1:0] opv_s0;
    logic [REG_SIZE-1:0] opw_s0;

    // GS difference ahead of the multiplier
    logic [REG_SIZE:0]   gs_diff;
    logic [REG_SIZE-1:0] gs_diff_mod;

    // Multiplier
    logic [REG_SIZE-1:0] mul_opa;
    logic [REG_SIZE-1:0] mul_opb;
    logic [REG_SIZE-1:0] mul_res;

    // Front unit, GS sum and point-wise add or subtract
    logic                front_sub;
    logic [REG_SIZE-1:0] front_res;
    logic [REG_SIZE-1:0] front_res_s5;

    // Back stage operands
    logic [REG_SIZE-1:0] u_s4;
    logic [REG_SIZE-1:0] w_s4;
    logic                ct_s4;
    logic [REG_SIZE-1:0] add_opa;
    logic [REG_SIZE-1:0] add_opb;
    logic [REG_SIZE-1:0] add_res;
    logic [REG_SIZE-1:0] sub_opa;
    logic [REG_SIZE-1:0] sub_opb;
    logic [REG_SIZE-1:0] sub_res;

    // x / 2 mod q, odd values become (x + q) / 2
    function automatic logic [REG_SIZE-1:0] half_mod(input logic [REG_SIZE-1:0] x);
        return x[0] ? (x >> 1) + NTT_Q_DIV2_ODD : (x >> 1);
    endfunction

    //==========================================================
    // Stage 0, operand selection
    //==========================================================

    always_comb begin
        tag_s0.valid      = op_i.valid;
        tag_s0.mode       = op_i.mode;
        tag_s0.accumulate = op_i.accumulate;
        opu_s0 = op_i.valid ? op_i.opu : '0;
        opv_s0 = op_i.valid ? op_i.opv : '0;
        opw_s0 = op_i.valid ? op_i.opw : '0;
    end

    // GS difference formed without a register, so every mode enters the
    // multiplier on stage 0 and mixed modes never compete for it
    always_comb begin
        gs_diff     = {1'b0, opu_s0} - {1'b0, opv_s0};
        gs_diff_mod = gs_diff[REG_SIZE] ? REG_SIZE'(gs_diff + {1'b0, NTT_Q})
                                        : gs_diff[REG_SIZE-1:0];
    end

    always_comb begin
        mul_opa = '0;
        mul_opb = '0;
        case (op_i.mode)
            ct: begin
                mul_opa = opv_s0;
                mul_opb = opw_s0;
            end
            gs: begin
                mul_opa = half_mod(gs_diff_mod);
                mul_opb = opw_s0;
            end
            pwm: begin
                mul_opa = opu_s0;
                mul_opb = opv_s0;
            end
            default: begin
            end
        endcase
    end

    // Subtract only for PWS, GS and PWA use the sum
    assign front_sub = (op_i.mode == pws);

    ntt_add_sub_mod i_front_add_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (front_sub),
        .opa_i     (opu_s0),
        .opb_i     (opv_s0),
        .res_o     (front_res)
    );

    ntt_mult_reduction i_mult_reduction (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .opa_i     (mul_opa),
        .opb_i     (mul_opb),
        .res_o     (mul_res)
    );

    //==========================================================
    // Alignment delays
    //==========================================================

    ntt_delay #(.T(bf_tag_t), .DEPTH(MUL_LAT)) i_tag_dly_s4 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .data_i(tag_s0), .data_o(tag_s4)
    );

    ntt_delay #(.T(bf_tag_t), .DEPTH(ADD_LAT)) i_tag_dly_s5 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .data_i(tag_s4), .data_o(tag_s5)
    );

    // u for CT, w as PWM accumulator
    ntt_delay #(.T(logic [REG_SIZE-1:0]), .DEPTH(MUL_LAT)) i_u_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .data_i(opu_s0), .data_o(u_s4)
    );

    ntt_delay #(.T(logic [REG_SIZE-1:0]), .DEPTH(MUL_LAT)) i_w_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .data_i(opw_s0), .data_o(w_s4)
    );

    // GS sum or point-wise result, already one cycle in
    ntt_delay #(.T(logic [REG_SIZE-1:0]), .DEPTH(MUL_LAT)) i_front_dly (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .data_i(front_res), .data_o(front_res_s5)
    );

    //==========================================================
    // Stage 4, back add and subtract on the product
    //==========================================================

    always_comb begin
        add_opa = '0;
        add_opb = '0;
        if (tag_s4.valid) begin
            case (tag_s4.mode)
                ct: begin
                    add_opa = u_s4;
                    add_opb = mul_res;
                end
                gs: begin
                    // Product plus zero, just one more cycle
                    add_opb = mul_res;
                end
                pwm: begin
                    add_opa = tag_s4.accumulate ? w_s4 : '0;
                    add_opb = mul_res;
                end
                default: begin
                end
            endcase
        end
    end

    // CT only
    assign ct_s4   = tag_s4.valid && (tag_s4.mode == ct);
    assign sub_opa = ct_s4 ? u_s4 : '0;
    assign sub_opb = ct_s4 ? mul_res : '0;

    ntt_add_sub_mod i_back_add (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b0),
        .opa_i     (add_opa),
        .opb_i     (add_opb),
        .res_o     (add_res)
    );

    ntt_add_sub_mod i_ct_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b1),
        .opa_i     (sub_opa),
        .opb_i     (sub_opb),
        .res_o     (sub_res)
    );

    //==========================================================
    // Stage 5, output select by the delayed tag
    //==========================================================

    // Point-wise modes put the result on both u_o and pwm_res_o
    always_comb begin
        valid_o   = tag_s5.valid;
        u_o       = '0;
        v_o       = '0;
        pwm_res_o = '0;
        if (tag_s5.valid) begin
            case (tag_s5.mode)
                ct: begin
                    u_o = add_res;
                    v_o = sub_res;
                end
                gs: begin
                    u_o = half_mod(front_res_s5);
                    v_o = add_res;
                end
                pwm: begin
                    u_o       = add_res;
                    pwm_res_o = add_res;
                end
                pwa, pws: begin
                    u_o       = front_res_s5;
                    pwm_res_o = front_res_s5;
                end
                default: begin
                end
            endcase
        end
    end

    // Single correction adders and the folds need reduced inputs
    a_operands_below_q: assert property (@(posedge clk) disable iff (!reset_n)
        op_i.valid |-> (op_i.opu < NTT_Q) && (op_i.opv < NTT_Q) && (op_i.opw < NTT_Q));

    // Tag pipe flushed together with the datapath
    a_zeroize_kills_valid: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> !valid_o);

endmodule

/* hdl/ntt_defines_pkg.sv */
//==========================================================
// NTT butterfly shared definitions
// Coefficient width, prime, operating modes and latencies
//==========================================================
package ntt_defines_pkg;

    //==========================================================
    // Arithmetic
    //==========================================================

    // Coefficient width
    localparam int REG_SIZE = 23;

    // q = 2^23 - 2^13 + 1
    localparam logic [REG_SIZE-1:0] NTT_Q = 23'd8380417;

    // (q + 1) / 2, added to x >> 1 when x is odd
    localparam logic [REG_SIZE-1:0] NTT_Q_DIV2_ODD = 23'd4190209;

    //==========================================================
    // Modes
    //==========================================================

    // Codes 5 to 7 are unused and give zero outputs
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } mode_t;

    //==========================================================
    // Pipeline latencies in clock cycles
    //==========================================================

    localparam int ADD_LAT = 1;
    localparam int MUL_LAT = 4;

    // Same for every mode
    localparam int BF_LAT = ADD_LAT + MUL_LAT;

endpackage

/* hdl/ntt_delay.sv */
//==========================================================
// Alignment shift register
// Delays any payload type by DEPTH cycles, zeroizable
//==========================================================
module ntt_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  T     data_i,
    output T     data_o
);

    // Stage 0 is the first register after the input
    T stage_q [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            // Flush everything in flight
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign data_o = stage_q[DEPTH-1];

endmodule

/* hdl/ntt_mult_reduction.sv */
//==========================================================
// Modular multiplier mod q, four pipeline stages
// Product, two folds with 2^23 = 2^13 - 1, final correction
//==========================================================
module ntt_mult_reduction
    import ntt_defines_pkg::*;
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,
    output logic [REG_SIZE-1:0] res_o
);

    // Stage 1, full 46-bit product
    logic [2*REG_SIZE-1:0] prod_q;
    // Stage 2, 23-bit high part folded, fits 37 bits
    logic [REG_SIZE+13:0]  fold1_d;
    logic [REG_SIZE+13:0]  fold1_q;
    // Stage 3, 14-bit high part folded to 28 bits, then its 5 top bits again
    logic [REG_SIZE+4:0]   fold2_mid;
    logic [REG_SIZE:0]     fold2_d;
    logic [REG_SIZE:0]     fold2_q;
    // Stage 4, reduced result
    logic [REG_SIZE-1:0]   res_q;

    //==========================================================
    // Folding, x = H*2^23 + L = (H << 13) - H + L mod q
    //==========================================================

    always_comb begin
        fold1_d = {1'b0, prod_q[2*REG_SIZE-1:REG_SIZE], 13'b0}
                + {14'b0, prod_q[REG_SIZE-1:0]}
                - {14'b0, prod_q[2*REG_SIZE-1:REG_SIZE]};

        fold2_mid = {1'b0, fold1_q[REG_SIZE+13:REG_SIZE], 13'b0}
                  + {5'b0, fold1_q[REG_SIZE-1:0]}
                  - {14'b0, fold1_q[REG_SIZE+13:REG_SIZE]};

        // Top part is at most 31 here, result stays below 2q
        fold2_d = {6'b0, fold2_mid[REG_SIZE+4:REG_SIZE], 13'b0}
                + {1'b0, fold2_mid[REG_SIZE-1:0]}
                - {19'b0, fold2_mid[REG_SIZE+4:REG_SIZE]};
    end

    //==========================================================
    // Pipeline registers
    //==========================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q  <= '0;
            fold1_q <= '0;
            fold2_q <= '0;
            res_q   <= '0;
        end else if (zeroize_i) begin
            prod_q  <= '0;
            fold1_q <= '0;
            fold2_q <= '0;
            res_q   <= '0;
        end else begin
            prod_q  <= {{REG_SIZE{1'b0}}, opa_i} * {{REG_SIZE{1'b0}}, opb_i};
            fold1_q <= fold1_d;
            fold2_q <= fold2_d;
            // Single conditional subtraction brings it below q
            res_q   <= (fold2_q >= {1'b0, NTT_Q}) ? REG_SIZE'(fold2_q - {1'b0, NTT_Q})
                                                  : fold2_q[REG_SIZE-1:0];
        end
    end

    assign res_o = res_q;

    // Relies on the two folds bounding stage 3 below 2q
    a_res_reduced: assert property (@(posedge clk) disable iff (!reset_n) res_o < NTT_Q);

endmodule

/* hdl/ntt_op_if.sv */
//==========================================================
// Butterfly operation bundle
// One operation per cycle, qualified by valid, no stall
//==========================================================
interface ntt_op_if
    import ntt_defines_pkg::*;
();

    // Operation strobe, taken on every rising edge where high
    logic                valid;
    logic                accumulate;
    mode_t               mode;

    // Operands, all below q when valid
    logic [REG_SIZE-1:0] opu;
    logic [REG_SIZE-1:0] opv;
    // Twiddle factor, or accumulator value in PWM
    logic [REG_SIZE-1:0] opw;

    // Issuing side
    modport producer (
        output valid, mode, accumulate, opu, opv, opw
    );

    // Butterfly side
    modport consumer (
        input valid, mode, accumulate, opu, opv, opw
    );

endinterface

/* ntt_bf_top.f */
hdl/ntt_defines_pkg.sv
hdl/ntt_op_if.sv
hdl/ntt_delay.sv
hdl/ntt_add_sub_mod.sv
hdl/ntt_mult_reduction.sv
hdl/ntt_butterfly.sv
hdl/ntt_bf_top.sv
+incdir+verif
verif/ntt_bf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the NTT butterfly testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ntt_bf_tb -f ntt_bf_top.f \
    -Mdir "$BUILD_DIR" -o ntt_bf_sim
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/ntt_bf_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "SIMULATION FAILED" "$LOG_FILE"; then
    echo "ERROR: testbench reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "ERROR: simulator exited with status $sim_status"
    exit 1
fi
exit 0

/* verif/ntt_bf_ref.svh */
//==========================================================
// Reference model for the NTT butterfly testbench
// Modular arithmetic per mode, plus the xorshift generator
//==========================================================
`ifndef NTT_BF_REF_SVH
`define NTT_BF_REF_SVH

// Expected values of the three result outputs
typedef struct packed {
    logic [REG_SIZE-1:0] u;
    logic [REG_SIZE-1:0] v;
    logic [REG_SIZE-1:0] pwm;
} bf_res_t;

//==========================================================
// Arithmetic mod q on wide integers
//==========================================================

function automatic logic [REG_SIZE-1:0] ref_add(input logic [REG_SIZE-1:0] a,
                                                input logic [REG_SIZE-1:0] b);
    return REG_SIZE'((longint'(a) + longint'(b)) % longint'(NTT_Q));
endfunction

function automatic logic [REG_SIZE-1:0] ref_sub(input logic [REG_SIZE-1:0] a,
                                                input logic [REG_SIZE-1:0] b);
    return REG_SIZE'((longint'(a) - longint'(b) + longint'(NTT_Q)) % longint'(NTT_Q));
endfunction

function automatic logic [REG_SIZE-1:0] ref_mul(input logic [REG_SIZE-1:0] a,
                                                input logic [REG_SIZE-1:0] b);
    return REG_SIZE'((longint'(a) * longint'(b)) % longint'(NTT_Q));
endfunction

// Odd values get q added before the division
function automatic logic [REG_SIZE-1:0] ref_half(input logic [REG_SIZE-1:0] x);
    if (x[0]) begin
        return REG_SIZE'((longint'(x) + longint'(NTT_Q)) / 2);
    end
    return REG_SIZE'(longint'(x) / 2);
endfunction

//==========================================================
// Per-mode butterfly result
//==========================================================

// Point-wise modes drive u_o and pwm_res_o with the same value
function automatic bf_res_t ref_butterfly(input mode_t mode, input logic acc,
                                          input logic [REG_SIZE-1:0] u,
                                          input logic [REG_SIZE-1:0] v,
                                          input logic [REG_SIZE-1:0] w);
    bf_res_t             r;
    logic [REG_SIZE-1:0] p;
    r = '0;
    case (mode)
        ct: begin
            p   = ref_mul(v, w);
            r.u = ref_add(u, p);
            r.v = ref_sub(u, p);
        end
        gs: begin
            r.u = ref_half(ref_add(u, v));
            r.v = ref_mul(ref_half(ref_sub(u, v)), w);
        end
        pwm: begin
            p = ref_mul(u, v);
            if (acc) begin
                p = ref_add(p, w);
            end
            r.u   = p;
            r.pwm = p;
        end
        pwa: begin
            r.u   = ref_add(u, v);
            r.pwm = r.u;
        end
        pws: begin
            r.u   = ref_sub(u, v);
            r.pwm = r.u;
        end
        default: begin
        end
    endcase
    return r;
endfunction

// 32-bit xorshift, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

/* verif/ntt_bf_tb.sv */
//==========================================================
// NTT butterfly testbench
// Directed and random operations in all modes, zeroize
//==========================================================
module ntt_bf_tb
    import ntt_defines_pkg::*;
();

    `include "ntt_bf_ref.svh"

    localparam int                  CLK_PERIOD   = 4;
    localparam logic [31:0]         SEED         = 32'hfe72_96cb;
    localparam logic [REG_SIZE-1:0] Q1           = NTT_Q - 1;

    // Stimulus lengths in cycles
    localparam int DIRECTED_OPS = 13;
    localparam int RAND_OPS     = 40;
    localparam int MIX_CYCLES   = 200;
    localparam int ZERO_BATCH   = 20;
    localparam int ZERO_CYCLES  = 2;
    localparam int DRAIN_CYCLES = BF_LAT + 2;
    localparam int OP_CYCLES    = DIRECTED_OPS + 5 * RAND_OPS + MIX_CYCLES + 2 * ZERO_BATCH;
    // Reset, eight drains and the zeroize pulse
    localparam int IDLE_CYCLES  = 4 + 8 * DRAIN_CYCLES + ZERO_CYCLES;

    // Operation waiting for its result, due is the compare cycle
    typedef struct packed {
        logic [31:0] due;
        bf_res_t     res;
    } pending_t;

    logic                clk;
    logic                reset_n;
    logic                zeroize_i;
    logic                valid_i;
    mode_t               mode_i;
    logic                accumulate_i;
    logic [REG_SIZE-1:0] opu_i;
    logic [REG_SIZE-1:0] opv_i;
    logic [REG_SIZE-1:0] opw_i;
    logic                valid_o;
    logic [REG_SIZE-1:0] u_o;
    logic [REG_SIZE-1:0] v_o;
    logic [REG_SIZE-1:0] pwm_res_o;

    logic [31:0] rng_state;
    int          cycle;
    pending_t    pending[$];

    ntt_bf_top i_ntt_bf_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .valid_i      (valid_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .opu_i        (opu_i),
        .opv_i        (opv_i),
        .opw_i        (opw_i),
        .valid_o      (valid_o),
        .u_o          (u_o),
        .v_o          (v_o),
        .pwm_res_o    (pwm_res_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //==========================================================
    // Reporting
    //==========================================================

    task automatic check_value(input string name, input logic [REG_SIZE-1:0] got,
                               input logic [REG_SIZE-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%06h, expected 0x%06h (cycle %0d)",
                     name, got, exp, cycle);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error at cycle %0d: %s", cycle, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    //==========================================================
    // Stimulus helpers, driven just after a rising edge
    //==========================================================

    task automatic issue_op(input mode_t m, input logic acc, input logic [REG_SIZE-1:0] u,
                            input logic [REG_SIZE-1:0] v, input logic [REG_SIZE-1:0] w);
        valid_i      <= 1'b1;
        mode_i       <= m;
        accumulate_i <= acc;
        opu_i        <= u;
        opv_i        <= v;
        opw_i        <= w;
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        valid_i <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic next_coeff(output logic [REG_SIZE-1:0] c);
        rng_state = xorshift32(rng_state);
        c = REG_SIZE'(rng_state % 32'(NTT_Q));
    endtask

    task automatic next_mode(output mode_t m);
        logic [7:0] sel;
        rng_state = xorshift32(rng_state);
        sel = rng_state[15:8] % 8'd5;
        m = mode_t'(sel[2:0]);
    endtask

    task automatic issue_random(input mode_t m);
        logic [REG_SIZE-1:0] u;
        logic [REG_SIZE-1:0] v;
        logic [REG_SIZE-1:0] w;
        next_coeff(u);
        next_coeff(v);
        next_coeff(w);
        rng_state = xorshift32(rng_state);
        issue_op(m, rng_state[0], u, v, w);
    endtask

    //==========================================================
    // Scoreboard
    //==========================================================

    // Compare first, then flush or record what the DUT samples at this edge
    always @(posedge clk) begin : scoreboard
        pending_t head;
        pending_t item;
        if (reset_n) begin
            if (valid_o) begin
                if (pending.size() == 0) begin
                    report_failure("valid_o went high with no operation outstanding");
                end
                head = pending.pop_front();
                if (head.due != 32'(cycle)) begin
                    report_failure("result arrived at the wrong cycle after its operation");
                end
                check_value("u_o", u_o, head.res.u);
                check_value("v_o", v_o, head.res.v);
                check_value("pwm_res_o", pwm_res_o, head.res.pwm);
            end else begin
                if (pending.size() != 0 && pending[0].due <= 32'(cycle)) begin
                    report_failure("no valid_o BF_LAT cycles after a valid operation");
                end
                // Idle outputs read zero
                check_value("u_o", u_o, '0);
                check_value("v_o", v_o, '0);
                check_value("pwm_res_o", pwm_res_o, '0);
            end
            // Zeroize also drops the operation sampled with it
            if (zeroize_i) begin
                pending.delete();
            end else if (valid_i) begin
                item.due = 32'(cycle + BF_LAT);
                item.res = ref_butterfly(mode_i, accumulate_i, opu_i, opv_i, opw_i);
                pending.push_back(item);
            end
        end
        cycle = cycle + 1;
    end

    //==========================================================
    // Test sequence
    //==========================================================

    initial begin : main
        mode_t m;
        clk          = 1'b0;
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        valid_i      = 1'b0;
        mode_i       = ct;
        accumulate_i = 1'b0;
        opu_i        = '0;
        opv_i        = '0;
        opw_i        = '0;
        rng_state    = SEED;
        cycle        = 0;

        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        // Directed corners, odd sums and differences for halving
        issue_op(ct, 1'b0, '0, '0, '0);
        issue_op(ct, 1'b0, Q1, Q1, Q1);
        issue_op(ct, 1'b0, '0, Q1, 23'd1);
        issue_op(gs, 1'b0, Q1, Q1, Q1);
        issue_op(gs, 1'b0, 23'd1, '0, 23'd5);
        issue_op(gs, 1'b0, '0, 23'd1, Q1);
        issue_op(gs, 1'b0, Q1, '0, 23'd2);
        issue_op(gs, 1'b0, 23'd2, 23'd1, 23'd3);
        issue_op(pwm, 1'b0, Q1, Q1, '0);
        issue_op(pwm, 1'b1, Q1, Q1, Q1);
        issue_op(pwa, 1'b0, Q1, Q1, '0);
        issue_op(pws, 1'b0, '0, Q1, '0);
        issue_op(pws, 1'b0, 23'd3, 23'd5, '0);
        idle_cycles(DRAIN_CYCLES);

        // One random burst per mode
        for (int k = 0; k < 5; k++) begin
            repeat (RAND_OPS) issue_random(mode_t'(k));
            idle_cycles(DRAIN_CYCLES);
        end

        // Mixed modes with idle gaps, about one cycle in four empty
        repeat (MIX_CYCLES) begin
            rng_state = xorshift32(rng_state);
            if (rng_state[1:0] == 2'b00) begin
                idle_cycles(1);
            end else begin
                next_mode(m);
                issue_random(m);
            end
        end
        idle_cycles(DRAIN_CYCLES);

        // Zeroize with operations in flight, then restart at once
        repeat (ZERO_BATCH) begin
            next_mode(m);
            issue_random(m);
        end
        valid_i   <= 1'b0;
        zeroize_i <= 1'b1;
        repeat (ZERO_CYCLES) @(posedge clk);
        zeroize_i <= 1'b0;
        repeat (ZERO_BATCH) begin
            next_mode(m);
            issue_random(m);
        end
        idle_cycles(DRAIN_CYCLES);

        if (pending.size() != 0) begin
            $display("Error: %0d operations never produced a result", pending.size());
            $display("SIMULATION FAILED");
            $fatal(1, "Results missing at end of test");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // Watchdog sized from the stimulus length plus margin
    initial begin : watchdog
        #((OP_CYCLES + IDLE_CYCLES + 20) * CLK_PERIOD);
        $display("Error: the test did not finish within the expected time");
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout");
    end

endmodule
